//--- design/necolink_defs.svh
`ifndef NECOLINK_DEFS_SVH
`define NECOLINK_DEFS_SVH

// ring population
`define NECO_MAX_SLAVES 4

// global area first, then one local area per slave
`define NECO_GLOBAL_BYTES 4
`define NECO_LOCAL_BYTES 4
`define NECO_LOCAL_OFFSET `NECO_GLOBAL_BYTES

// whole payload seen on the response path
`define NECO_FULL_BYTES (`NECO_GLOBAL_BYTES + `NECO_LOCAL_BYTES * `NECO_MAX_SLAVES)

// payload byte index
`define NECO_INDEX_W 16

`endif

//--- design/necolink_pkg.sv
`include "necolink_defs.svh"

package necolink_pkg;

    // --------------------
    // payload byte arrays
    // --------------------

    // byte 0 is the lowest index of its window
    typedef logic [`NECO_GLOBAL_BYTES-1:0][7:0] global_bytes_t;
    typedef logic [`NECO_LOCAL_BYTES-1:0][7:0]  local_bytes_t;
    typedef logic [`NECO_FULL_BYTES-1:0][7:0]   full_bytes_t;

    // --------------------
    // stream index
    // --------------------

    typedef logic [`NECO_INDEX_W-1:0] index_t;

endpackage

//--- design/payload_if.sv
`timescale 1ns/100ps

interface payload_if;
    import necolink_pkg::*;

    // data and index only meaningful while valid
    index_t     index;
    logic       first;
    logic       last;
    logic [7:0] data;
    logic       valid;

    modport src (
        output index,
        output first,
        output last,
        output data,
        output valid
    );

    modport snk (
        input index,
        input first,
        input last,
        input data,
        input valid
    );

endinterface

//--- design/packet_position.sv
`timescale 1ns/100ps

module packet_position #(
    parameter int width = 4
) (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 setup,
    input  necolink_pkg::index_t offset,
    payload_if.snk               stream,
    output logic [width-1:0]     flags,
    output logic                 flag
);
    import necolink_pkg::*;

    index_t offset_q;
    logic   armed;

    // window armed from setup until the last byte of the frame
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            offset_q <= '0;
            armed    <= 1'b0;
        end else if (setup) begin
            offset_q <= offset;
            armed    <= 1'b1;
        end else if (stream.valid && stream.last) begin
            armed <= 1'b0;
        end
    end

    // one flag per window byte
    always_comb begin
        for (int i = 0; i < width; i++) begin
            flags[i] = armed && stream.valid && (stream.index == offset_q + index_t'(i));
        end
    end

    assign flag = |flags;

    // --------------------
    // checks
    // --------------------

    // window bytes have distinct indices
    a_flags_onehot: assert property (
        @(posedge clk) disable iff (!arst_n)
        $onehot0(flags)
    );

    // frame start marker sits on payload byte 0
    a_first_at_zero: assert property (
        @(posedge clk) disable iff (!arst_n)
        (stream.valid && stream.first) |-> (stream.index == '0)
    );

endmodule

//--- design/payload_capture.sv
`timescale 1ns/100ps

module payload_capture #(
    parameter type payload_t = necolink_pkg::global_bytes_t
) (
    input  logic                          clk,
    input  logic                          arst_n,
    payload_if.snk                        stream,
    input  logic [$bits(payload_t)/8-1:0] flags,
    output payload_t                      captured
);

    localparam int lanes = $bits(payload_t) / 8;

    logic [lanes-1:0][7:0] lane_q;

    // flagged lanes take the stream byte, the rest hold
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            lane_q <= '0;
        end else begin
            for (int i = 0; i < lanes; i++) begin
                if (flags[i]) begin
                    lane_q[i] <= stream.data;
                end
            end
        end
    end

    assign captured = payload_t'(lane_q);

    // --------------------
    // checks
    // --------------------

    // decoder only flags bytes that are on the stream
    a_flag_needs_valid: assert property (
        @(posedge clk) disable iff (!arst_n)
        (|flags) |-> stream.valid
    );

endmodule

//--- design/gpio_overlay.sv
`timescale 1ns/100ps

module gpio_overlay (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        setup,
    input  necolink_pkg::global_bytes_t tx_global_mask,
    input  necolink_pkg::global_bytes_t tx_global_data,
    input  necolink_pkg::local_bytes_t  tx_local_mask,
    input  necolink_pkg::local_bytes_t  tx_local_data,
    payload_if.snk                      stream,
    input  logic                        global_hit,
    input  logic                        local_hit,
    output logic [7:0]                  fwd_data,
    output logic                        fwd_valid,
    input  logic                        fwd_ready
);
    import necolink_pkg::*;

    global_bytes_t global_mask_q;
    global_bytes_t global_data_q;
    local_bytes_t  local_mask_q;
    local_bytes_t  local_data_q;

    logic [7:0] overlay;
    logic       hit;

    // --------------------
    // overlay
    // --------------------

    // local overlay applied on top of the global one
    always_comb begin
        overlay = stream.data;
        if (global_hit) begin
            overlay = (overlay & ~global_mask_q[0]) | (global_data_q[0] & global_mask_q[0]);
        end
        if (local_hit) begin
            overlay = (overlay & ~local_mask_q[0]) | (local_data_q[0] & local_mask_q[0]);
        end
    end

    assign hit = stream.valid && (global_hit || local_hit);

    // byte 0 always holds the bits for the next hit byte
    always_ff @(posedge clk) begin
        if (setup) begin
            global_mask_q <= tx_global_mask;
            global_data_q <= tx_global_data;
            local_mask_q  <= tx_local_mask;
            local_data_q  <= tx_local_data;
        end else if (stream.valid) begin
            if (global_hit) begin
                global_mask_q <= global_mask_q >> 8;
                global_data_q <= global_data_q >> 8;
            end
            if (local_hit) begin
                local_mask_q <= local_mask_q >> 8;
                local_data_q <= local_data_q >> 8;
            end
        end
    end

    // --------------------
    // forwarding register
    // --------------------

    // a new byte wins over ready, the stream never waits
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            fwd_valid <= 1'b0;
        end else if (hit) begin
            fwd_valid <= 1'b1;
        end else if (fwd_ready) begin
            fwd_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (hit) begin
            fwd_data <= overlay;
        end
    end

    a_fwd_valid_known: assert property (
        @(posedge clk) disable iff (!arst_n)
        !$isunknown(fwd_valid)
    );

endmodule

//--- design/gpio_node.sv
`timescale 1ns/100ps
`include "necolink_defs.svh"

module gpio_node (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic [7:0]                  node_self,
    input  necolink_pkg::global_bytes_t tx_global_mask,
    input  necolink_pkg::global_bytes_t tx_global_data,
    input  necolink_pkg::local_bytes_t  tx_local_mask,
    input  necolink_pkg::local_bytes_t  tx_local_data,
    output logic                        tx_accepted,
    output necolink_pkg::global_bytes_t rx_global_data,
    output necolink_pkg::local_bytes_t  rx_local_data,
    output logic                        rx_valid,
    output necolink_pkg::full_bytes_t   res_full_data,
    output logic                        res_valid,
    input  logic                        cmd_enable,
    input  logic                        cmd_setup,
    input  logic                        cmd_finish,
    input  necolink_pkg::index_t        cmd_index,
    input  logic                        cmd_first,
    input  logic                        cmd_last,
    input  logic [7:0]                  cmd_data,
    input  logic                        cmd_valid,
    output logic [7:0]                  fwd_data,
    output logic                        fwd_valid,
    input  logic                        fwd_ready,
    input  logic                        res_enable,
    input  logic                        res_setup,
    input  logic                        res_finish,
    input  necolink_pkg::index_t        res_index,
    input  logic                        res_first,
    input  logic                        res_last,
    input  logic [7:0]                  res_data,
    input  logic                        res_valid_in
);
    import necolink_pkg::*;

    logic cmd_setup_en;
    logic res_setup_en;

    index_t local_offset_d;
    index_t local_offset_q;
    index_t local_offset;

    logic [`NECO_GLOBAL_BYTES-1:0] cmd_global_flags;
    logic [`NECO_LOCAL_BYTES-1:0]  cmd_local_flags;
    logic [`NECO_FULL_BYTES-1:0]   res_full_flags;
    logic                          cmd_global_hit;
    logic                          cmd_local_hit;

    payload_if cmd_if ();
    payload_if res_if ();

    assign cmd_if.index = cmd_index;
    assign cmd_if.first = cmd_first;
    assign cmd_if.last  = cmd_last;
    assign cmd_if.data  = cmd_data;
    assign cmd_if.valid = cmd_valid;

    assign res_if.index = res_index;
    assign res_if.first = res_first;
    assign res_if.last  = res_last;
    assign res_if.data  = res_data;
    assign res_if.valid = res_valid_in;

    assign cmd_setup_en = cmd_setup & cmd_enable;
    assign res_setup_en = res_setup & res_enable;

    assign tx_accepted = cmd_setup_en;
    assign rx_valid    = cmd_finish & cmd_enable;
    assign res_valid   = res_finish & res_enable;

    // --------------------
    // local window offset
    // --------------------

    // slaves are numbered from 2
    assign local_offset_d = index_t'(`NECO_LOCAL_OFFSET)
                          + (index_t'(node_self) - index_t'(2)) * index_t'(`NECO_LOCAL_BYTES);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            local_offset_q <= '0;
        end else if (cmd_setup_en) begin
            local_offset_q <= local_offset_d;
        end
    end

    // bypass so the decoder latches this frame's node number
    assign local_offset = cmd_setup_en ? local_offset_d : local_offset_q;

    // --------------------
    // command path
    // --------------------

    packet_position #(.width(`NECO_GLOBAL_BYTES)) i_cmd_global_pos (
        .clk    (clk),
        .arst_n (arst_n),
        .setup  (cmd_setup_en),
        .offset ('0),
        .stream (cmd_if.snk),
        .flags  (cmd_global_flags),
        .flag   (cmd_global_hit)
    );

    packet_position #(.width(`NECO_LOCAL_BYTES)) i_cmd_local_pos (
        .clk    (clk),
        .arst_n (arst_n),
        .setup  (cmd_setup_en),
        .offset (local_offset),
        .stream (cmd_if.snk),
        .flags  (cmd_local_flags),
        .flag   (cmd_local_hit)
    );

    payload_capture #(.payload_t(global_bytes_t)) i_cmd_global_cap (
        .clk      (clk),
        .arst_n   (arst_n),
        .stream   (cmd_if.snk),
        .flags    (cmd_global_flags),
        .captured (rx_global_data)
    );

    payload_capture #(.payload_t(local_bytes_t)) i_cmd_local_cap (
        .clk      (clk),
        .arst_n   (arst_n),
        .stream   (cmd_if.snk),
        .flags    (cmd_local_flags),
        .captured (rx_local_data)
    );

    gpio_overlay i_gpio_overlay (
        .clk            (clk),
        .arst_n         (arst_n),
        .setup          (cmd_setup_en),
        .tx_global_mask (tx_global_mask),
        .tx_global_data (tx_global_data),
        .tx_local_mask  (tx_local_mask),
        .tx_local_data  (tx_local_data),
        .stream         (cmd_if.snk),
        .global_hit     (cmd_global_hit),
        .local_hit      (cmd_local_hit),
        .fwd_data       (fwd_data),
        .fwd_valid      (fwd_valid),
        .fwd_ready      (fwd_ready)
    );

    // --------------------
    // response path
    // --------------------

    packet_position #(.width(`NECO_FULL_BYTES)) i_res_full_pos (
        .clk    (clk),
        .arst_n (arst_n),
        .setup  (res_setup_en),
        .offset ('0),
        .stream (res_if.snk),
        .flags  (res_full_flags),
        .flag   ()
    );

    payload_capture #(.payload_t(full_bytes_t)) i_res_full_cap (
        .clk      (clk),
        .arst_n   (arst_n),
        .stream   (res_if.snk),
        .flags    (res_full_flags),
        .captured (res_full_data)
    );

endmodule

//--- verification/gpio_node_tb.sv
`timescale 1ns/100ps
`include "necolink_defs.svh"

module gpio_node_tb;
    import necolink_pkg::*;

    localparam int half_period  = 10;
    localparam int cmd_frames   = 8;
    localparam int res_frames   = 4;
    localparam int total_frames = cmd_frames + 3 + res_frames;
    // one idle gap at most per byte, plus setup, finish, stall and drain
    localparam int frame_cycles = 2 * `NECO_FULL_BYTES + 10;
    localparam int watchdog_ns  = (total_frames * frame_cycles + 18) * 2 * half_period;

    logic          clk = 1'b0;
    logic          arst_n;
    logic [7:0]    node_self;
    global_bytes_t tx_global_mask, tx_global_data, rx_global_data;
    local_bytes_t  tx_local_mask, tx_local_data, rx_local_data;
    full_bytes_t   res_full_data;
    logic          tx_accepted, rx_valid, res_valid;
    logic          cmd_enable, cmd_setup, cmd_finish, cmd_first, cmd_last, cmd_valid;
    index_t        cmd_index, res_index;
    logic [7:0]    cmd_data, res_data, fwd_data;
    logic          fwd_valid, fwd_ready;
    logic          res_enable, res_setup, res_finish, res_first, res_last, res_valid_in;

    logic [31:0]   rng_state = 32'hc4ee;
    global_bytes_t exp_global = '0;
    local_bytes_t  exp_local = '0;
    full_bytes_t   exp_full = '0;
    logic [7:0]    exp_fwd [0:255];
    int            fwd_wr = 0;
    int            fwd_rd = 0;
    int            setups_sent = 0;
    int            accepted_seen = 0;
    logic          expect_accept = 1'b0;
    logic          expect_rx = 1'b0;
    logic          expect_res = 1'b0;

    gpio_node i_gpio_node (.*);

    always #(half_period) clk = ~clk;

    // --------------------
    // helpers
    // --------------------

    function logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function logic [7:0] random_byte();
        logic [31:0] r;
        r = next_random();
        return r[7:0];
    endfunction

    // slaves are numbered from 2
    function logic [7:0] random_node();
        return 8'd2 + (random_byte() % `NECO_MAX_SLAVES);
    endfunction

    task automatic mismatch_stop(input string msg);
        $display("mismatch at %0d ns: %s", $time, msg);
        $display("=== FAIL ===");
        $fatal(1, "stopped at first error");
    endtask

    task automatic error_stop(input string msg);
        $display("error at %0d ns: %s", $time, msg);
        $display("=== FAIL ===");
        $fatal(1, "stopped at first error");
    endtask

    // captures and forwarded bytes expected for one command frame
    function automatic void expected_frame(
        input  full_bytes_t   frame,
        input  logic [7:0]    node,
        input  global_bytes_t gmask,
        input  global_bytes_t gdata,
        input  local_bytes_t  lmask,
        input  local_bytes_t  ldata,
        output global_bytes_t g_exp,
        output local_bytes_t  l_exp,
        output full_bytes_t   fwd,
        output int            n_fwd
    );
        int         off;
        int         i;
        logic [7:0] b;
        logic       hit;
        off   = `NECO_LOCAL_OFFSET + (int'(node) - 2) * `NECO_LOCAL_BYTES;
        fwd   = '0;
        n_fwd = 0;
        for (i = 0; i < `NECO_GLOBAL_BYTES; i++) begin
            g_exp[i] = frame[i];
        end
        for (i = 0; i < `NECO_LOCAL_BYTES; i++) begin
            l_exp[i] = frame[off + i];
        end
        for (i = 0; i < `NECO_FULL_BYTES; i++) begin
            b   = frame[i];
            hit = 1'b0;
            if (i < `NECO_GLOBAL_BYTES) begin
                b   = (b & ~gmask[i]) | (gdata[i] & gmask[i]);
                hit = 1'b1;
            end
            if (i >= off && i < off + `NECO_LOCAL_BYTES) begin
                b   = (b & ~lmask[i - off]) | (ldata[i - off] & lmask[i - off]);
                hit = 1'b1;
            end
            if (hit) begin
                fwd[n_fwd] = b;
                n_fwd++;
            end
        end
    endfunction

    task automatic wait_forwarded();
        while (fwd_rd != fwd_wr) begin
            @(negedge clk);
        end
    endtask

    // --------------------
    // frames
    // --------------------

    task automatic run_command_frame(input logic enable, input logic stall);
        full_bytes_t   frame, fwd_list;
        global_bytes_t gm, gd, g_exp;
        local_bytes_t  lm, ld, l_exp;
        logic [7:0]    node;
        int            n_fwd;
        int            i;
        for (i = 0; i < `NECO_FULL_BYTES; i++) begin
            frame[i] = random_byte();
        end
        for (i = 0; i < `NECO_GLOBAL_BYTES; i++) begin
            gm[i] = random_byte();
            gd[i] = random_byte();
        end
        for (i = 0; i < `NECO_LOCAL_BYTES; i++) begin
            lm[i] = random_byte();
            ld[i] = random_byte();
        end
        node = random_node();
        expected_frame(frame, node, gm, gd, lm, ld, g_exp, l_exp, fwd_list, n_fwd);
        if (enable) begin
            exp_global = g_exp;
            exp_local  = l_exp;
            setups_sent++;
            for (i = stall ? n_fwd - 1 : 0; i < n_fwd; i++) begin
                exp_fwd[fwd_wr] = fwd_list[i];
                fwd_wr++;
            end
        end

        cmd_enable     = enable;
        cmd_setup      = 1'b1;
        expect_accept  = enable;
        node_self      = node;
        tx_global_mask = gm;
        tx_global_data = gd;
        tx_local_mask  = lm;
        tx_local_data  = ld;
        fwd_ready      = !stall;
        @(negedge clk);
        cmd_setup     = 1'b0;
        expect_accept = 1'b0;
        // later changes must not reach this frame
        node_self      = random_node();
        tx_global_mask = ~gm;
        tx_local_data  = ~ld;
        for (i = 0; i < `NECO_FULL_BYTES; i++) begin
            if (random_byte() < 8'd64) begin
                cmd_valid = 1'b0;
                cmd_index = index_t'(i);
                cmd_data  = random_byte();
                @(negedge clk);
            end
            cmd_valid = 1'b1;
            cmd_index = index_t'(i);
            cmd_first = (i == 0);
            cmd_last  = (i == `NECO_FULL_BYTES - 1);
            cmd_data  = frame[i];
            @(negedge clk);
        end
        cmd_valid = 1'b0;
        cmd_first = 1'b0;
        cmd_last  = 1'b0;
        @(negedge clk);
        cmd_finish = 1'b1;
        expect_rx  = enable;
        @(negedge clk);
        cmd_finish = 1'b0;
        expect_rx  = 1'b0;

        if (stall) begin
            repeat (4) begin
                assert (fwd_valid === 1'b1 && fwd_data === fwd_list[n_fwd - 1])
                    else mismatch_stop($sformatf("held byte %h valid %b, expected %h",
                                                 fwd_data, fwd_valid, fwd_list[n_fwd - 1]));
                @(negedge clk);
            end
            fwd_ready = 1'b1;
        end
        wait_forwarded();
        assert (rx_global_data == exp_global && rx_local_data == exp_local)
            else mismatch_stop("captured command data differs after the frame");
        cmd_enable = 1'b1;
    endtask

    task automatic send_response_frame();
        full_bytes_t frame;
        int          i;
        for (i = 0; i < `NECO_FULL_BYTES; i++) begin
            frame[i] = random_byte();
        end
        exp_full = frame;
        res_enable = 1'b1;
        res_setup  = 1'b1;
        @(negedge clk);
        res_setup = 1'b0;
        for (i = 0; i < `NECO_FULL_BYTES; i++) begin
            if (random_byte() < 8'd64) begin
                res_valid_in = 1'b0;
                res_data     = random_byte();
                @(negedge clk);
            end
            res_valid_in = 1'b1;
            res_index    = index_t'(i);
            res_first    = (i == 0);
            res_last     = (i == `NECO_FULL_BYTES - 1);
            res_data     = frame[i];
            @(negedge clk);
        end
        res_valid_in = 1'b0;
        res_first    = 1'b0;
        res_last     = 1'b0;
        res_finish   = 1'b1;
        expect_res   = 1'b1;
        @(negedge clk);
        res_finish = 1'b0;
        expect_res = 1'b0;
    endtask

    // --------------------
    // compare
    // --------------------

    always @(posedge clk) begin
        if (arst_n) begin
            assert (tx_accepted === expect_accept)
                else mismatch_stop($sformatf("tx_accepted %b, expected %b",
                                             tx_accepted, expect_accept));
            assert (rx_valid === expect_rx)
                else mismatch_stop($sformatf("rx_valid %b, expected %b",
                                             rx_valid, expect_rx));
            assert (res_valid === expect_res)
                else mismatch_stop($sformatf("res_valid %b, expected %b",
                                             res_valid, expect_res));
            if (tx_accepted) begin
                accepted_seen++;
            end
            if (rx_valid) begin
                assert (rx_global_data == exp_global)
                    else mismatch_stop($sformatf("rx_global_data %h, expected %h",
                                                 rx_global_data, exp_global));
                assert (rx_local_data == exp_local)
                    else mismatch_stop($sformatf("rx_local_data %h, expected %h",
                                                 rx_local_data, exp_local));
            end
            if (res_valid) begin
                assert (res_full_data == exp_full)
                    else mismatch_stop($sformatf("res_full_data %h, expected %h",
                                                 res_full_data, exp_full));
            end
            if (fwd_valid && fwd_ready) begin
                assert (fwd_rd < fwd_wr)
                    else error_stop("a byte was forwarded when none was expected");
                assert (fwd_data == exp_fwd[fwd_rd])
                    else mismatch_stop($sformatf("fwd_data %h, expected %h",
                                                 fwd_data, exp_fwd[fwd_rd]));
                fwd_rd++;
            end
        end
    end

    // --------------------
    // main sequence
    // --------------------

    initial begin
        arst_n = 1'b0;
        {node_self, tx_global_mask, tx_global_data, tx_local_mask, tx_local_data} = '0;
        {cmd_enable, cmd_setup, cmd_finish, cmd_first, cmd_last, cmd_valid} = '0;
        {res_enable, res_setup, res_finish, res_first, res_last, res_valid_in} = '0;
        cmd_index = '0;
        res_index = '0;
        cmd_data  = '0;
        res_data  = '0;
        fwd_ready = 1'b1;
        repeat (16) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);
        assert (!fwd_valid && !tx_accepted && !rx_valid && !res_valid
                && rx_global_data == '0 && rx_local_data == '0 && res_full_data == '0)
            else error_stop("outputs are not cleared after reset");

        repeat (cmd_frames) run_command_frame(1'b1, 1'b0);
        run_command_frame(1'b0, 1'b0);
        run_command_frame(1'b1, 1'b1);
        run_command_frame(1'b1, 1'b0);
        repeat (res_frames) send_response_frame();
        repeat (2) @(negedge clk);

        assert (accepted_seen == setups_sent)
            else error_stop("tx_accepted pulse count differs from enabled setups");
        $display("=== PASS ===");
        $finish;
    end

    initial begin
        #(watchdog_ns);
        $display("error: watchdog expired before the tests finished");
        $display("=== FAIL ===");
        $fatal(1, "watchdog timeout");
    end

endmodule

//--- src.f
+incdir+design
design/necolink_pkg.sv
design/payload_if.sv
design/packet_position.sv
design/payload_capture.sv
design/gpio_overlay.sv
design/gpio_node.sv
verification/gpio_node_tb.sv

//--- Bender.yml
package:
  name: gpio_node

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/necolink_pkg.sv
      - design/payload_if.sv
      - design/packet_position.sv
      - design/payload_capture.sv
      - design/gpio_overlay.sv
      - design/gpio_node.sv
  - target: test
    include_dirs:
      - design
    files:
      - verification/gpio_node_tb.sv
